//--- source/cdp_rdma_ig_params.svh
// width and constant macros for the cdp read dma ingress
// included by the package and by any module that sizes a bus from them

`ifndef CDP_RDMA_IG_PARAMS_SVH
`define CDP_RDMA_IG_PARAMS_SVH

// address widths
`define CDP_ADDR_BW 64
`define CDP_MEM_ADDR_BW 64

// request size field, elements minus one, zero extended
`define CDP_SIZE_BW 15

// read request payload is address bits plus size bits
`define CDP_DMA_PD_BW 79

// log2 of memory atomic size in bytes
`define CDP_ATOMIC_SHIFT 3
// log2 of elements per width group
`define CDP_WGRP_SHIFT 3

// cube dimension registers and perf counters
`define CDP_DIM_BW 13
`define CDP_PERF_BW 32

`endif

//--- source/cdp_rdma_ig_pkg.sv
// shared types for the cdp read dma ingress
// modules name these types by scope in their ports and import the
// package in their bodies

`include "cdp_rdma_ig_params.svh"

package cdp_rdma_ig_pkg;

  // memory address and stride registers
  typedef logic [`CDP_ADDR_BW-1:0] addr_t;
  typedef logic [31:0] stride_t;

  // cube dimension, programmed as size minus one
  typedef logic [`CDP_DIM_BW-1:0] dim_t;

  // walk counters
  typedef logic [`CDP_DIM_BW-`CDP_WGRP_SHIFT:0] wgrp_cnt_t;
  typedef logic [`CDP_DIM_BW-`CDP_ATOMIC_SHIFT-1:0] chn_cnt_t;

  // elements in one request minus one
  typedef logic [`CDP_WGRP_SHIFT-1:0] req_size_t;

  typedef logic [`CDP_PERF_BW-1:0] perf_t;

  // context entry pushed to the egress with every request
  // top down: last_c, last_h, last_w, align, size
  typedef struct packed {
    logic      last_c;
    logic      last_h;
    logic      last_w;
    logic      align;
    req_size_t size;
  } cq_pd_t;

endpackage

//--- source/cdp_rdma_ig_req_seq.sv
// layer control and cube walk for the cdp read dma ingress
// walks width groups of eight, then channel blocks, then lines,
// and pairs the read request valid with the context queue valid

`include "cdp_rdma_ig_params.svh"

module cdp_rdma_ig_req_seq (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  logic                       op_en,
  input  logic                       eg2ig_done,
  input  cdp_rdma_ig_pkg::dim_t      width,
  input  cdp_rdma_ig_pkg::dim_t      height,
  input  cdp_rdma_ig_pkg::dim_t      channel,
  input  logic                       dma_ready,
  input  logic                       cq_ready,
  output logic                       dma_valid,
  output logic                       cq_valid,
  output logic                       op_load,
  output logic                       cmd_accept,
  output logic                       op_done,
  output logic                       is_last_w,
  output logic                       is_last_h,
  output logic                       is_last_c,
  output cdp_rdma_ig_pkg::req_size_t req_size
);
  import cdp_rdma_ig_pkg::*;

  logic                 active;
  logic                 waiting;
  chn_cnt_t             channel_count;
  wgrp_cnt_t            width_count;
  dim_t                 height_count;
  logic [`CDP_DIM_BW:0] width_use;
  wgrp_cnt_t            num_wgrp;
  logic                 is_slice_end;
  logic                 is_cube_end;

  // ==========================================================
  // layer control
  // ==========================================================
  // new layer only when idle and egress has drained the last one
  assign op_load = op_en & ~active & ~waiting;
  assign op_done = cmd_accept & is_cube_end;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      active <= 1'b0;
    end else if (op_done) begin
      active <= 1'b0;
    end else if (op_load) begin
      active <= 1'b1;
    end
  end

  // hold off until egress reports the layer done
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      waiting <= 1'b0;
    end else if (op_done) begin
      waiting <= 1'b1;
    end else if (eg2ig_done) begin
      waiting <= 1'b0;
    end
  end

  // ==========================================================
  // paired handshake
  // ==========================================================
  // each valid waits on the other side's ready so both accept together
  assign dma_valid  = active & cq_ready;
  assign cq_valid   = active & dma_ready;
  assign cmd_accept = dma_valid & dma_ready;

  // ==========================================================
  // cube walk
  // ==========================================================
  // ceil((width+1)/8) groups along the line
  assign width_use = (`CDP_DIM_BW+1)'(width) + (`CDP_DIM_BW+1)'(1);
  assign num_wgrp  = width_use[`CDP_DIM_BW:`CDP_WGRP_SHIFT]
                   + wgrp_cnt_t'(|width_use[`CDP_WGRP_SHIFT-1:0]);

  assign is_last_w    = (width_count == num_wgrp - wgrp_cnt_t'(1));
  assign is_last_h    = (height_count == height);
  assign is_last_c    = (channel_count == chn_cnt_t'(channel >> `CDP_ATOMIC_SHIFT));
  assign is_slice_end = is_last_w & is_last_c;
  assign is_cube_end  = is_slice_end & is_last_h;

  // channel block steps on every accept
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      channel_count <= '0;
    end else if (cmd_accept) begin
      if (is_last_c) begin
        channel_count <= '0;
      end else begin
        channel_count <= channel_count + chn_cnt_t'(1);
      end
    end
  end

  // width group steps after the last channel block
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      width_count <= '0;
    end else if (cmd_accept) begin
      if (is_slice_end) begin
        width_count <= '0;
      end else if (is_last_c) begin
        width_count <= width_count + wgrp_cnt_t'(1);
      end
    end
  end

  // line steps after the last group of a line
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      height_count <= '0;
    end else if (cmd_accept) begin
      if (is_cube_end) begin
        height_count <= '0;
      end else if (is_slice_end) begin
        height_count <= height_count + dim_t'(1);
      end
    end
  end

  // ==========================================================
  // request size
  // ==========================================================
  // the last or only group takes the width remainder
  // every other group is full
  always_comb begin
    if (is_last_w) begin
      req_size = width[`CDP_WGRP_SHIFT-1:0];
    end else begin
      req_size = '1;
    end
  end

endmodule

//--- source/cdp_rdma_ig_addr_gen.sv
// read request address generation for the cdp read dma ingress
// keeps the line base, the channel-group base and the current request
// address, all stepped on accepted requests

`include "cdp_rdma_ig_params.svh"

module cdp_rdma_ig_addr_gen (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  logic                       op_load,
  input  logic                       cmd_accept,
  input  logic                       is_last_w,
  input  logic                       is_last_c,
  input  cdp_rdma_ig_pkg::req_size_t req_size,
  input  logic [31:0]                base_addr_high,
  input  logic [31:0]                base_addr_low,
  input  cdp_rdma_ig_pkg::stride_t   line_stride,
  input  cdp_rdma_ig_pkg::stride_t   surf_stride,
  output cdp_rdma_ig_pkg::addr_t     req_addr
);
  import cdp_rdma_ig_pkg::*;

  addr_t                   base_addr;
  addr_t                   base_addr_w;
  addr_t                   base_addr_c;
  addr_t                   line_next;
  addr_t                   grp_next;
  logic [`CDP_WGRP_SHIFT:0] size_use;

  assign base_addr = addr_t'({base_addr_high, base_addr_low});

  // start of the next line
  assign line_next = base_addr_w + addr_t'(line_stride);

  // next group sits (size+1) atoms further along the line
  assign size_use = (`CDP_WGRP_SHIFT+1)'(req_size) + (`CDP_WGRP_SHIFT+1)'(1);
  assign grp_next = base_addr_c + addr_t'({size_use, {`CDP_ATOMIC_SHIFT{1'b0}}});

  // ==========================================================
  // line base
  // ==========================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_w <= '0;
    end else if (op_load) begin
      base_addr_w <= base_addr;
    end else if (cmd_accept && is_last_c && is_last_w) begin
      base_addr_w <= line_next;
    end
  end

  // ==========================================================
  // channel-group base
  // ==========================================================
  // moves at the end of each group's channel walk
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_c <= '0;
    end else if (op_load) begin
      base_addr_c <= base_addr;
    end else if (cmd_accept && is_last_c) begin
      base_addr_c <= is_last_w ? line_next : grp_next;
    end
  end

  // ==========================================================
  // request address
  // ==========================================================
  // inside a group, hop one surface per channel block
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_addr <= '0;
    end else if (op_load) begin
      req_addr <= base_addr;
    end else if (cmd_accept) begin
      if (!is_last_c) begin
        req_addr <= req_addr + addr_t'(surf_stride);
      end else if (is_last_w) begin
        req_addr <= line_next;
      end else begin
        req_addr <= grp_next;
      end
    end
  end

endmodule

//--- source/cdp_rdma_ig_stall_perf.sv
// read stall performance counter for the cdp read dma ingress
// counts cycles where a request waits on the memory side and latches
// the total into one of two registers, alternating per layer

module cdp_rdma_ig_stall_perf (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   dma_en,
  input  logic                   dma_valid,
  input  logic                   dma_ready,
  input  logic                   op_done,
  output cdp_rdma_ig_pkg::perf_t perf_read_stall_d0,
  output cdp_rdma_ig_pkg::perf_t perf_read_stall_d1
);
  import cdp_rdma_ig_pkg::*;

  perf_t stall_cnt;
  logic  stall;
  logic  layer_flag;

  // request offered but memory side not taking it
  assign stall = dma_en & dma_valid & ~dma_ready;

  // clears at every layer end, enabled or not
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (op_done) begin
      stall_cnt <= '0;
    end else if (stall) begin
      stall_cnt <= stall_cnt + perf_t'(1);
    end
  end

  // ==========================================================
  // ping-pong result registers
  // ==========================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_flag <= 1'b0;
    end else if (op_done) begin
      layer_flag <= ~layer_flag;
    end
  end

  // even layers land in d0, odd layers in d1
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      perf_read_stall_d0 <= '0;
      perf_read_stall_d1 <= '0;
    end else if (op_done) begin
      if (layer_flag) begin
        perf_read_stall_d1 <= stall_cnt;
      end else begin
        perf_read_stall_d0 <= stall_cnt;
      end
    end
  end

endmodule

//--- source/cdp_rdma_ig.sv
// cdp read dma ingress top level
// issues one read request per cube step and a matching context entry
// for the egress, plus the per-layer read stall counts

`include "cdp_rdma_ig_params.svh"

module cdp_rdma_ig (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic                         reg2dp_op_en,
  input  logic                         reg2dp_dma_en,
  input  cdp_rdma_ig_pkg::dim_t        reg2dp_width,
  input  cdp_rdma_ig_pkg::dim_t        reg2dp_height,
  input  cdp_rdma_ig_pkg::dim_t        reg2dp_channel,
  input  logic [31:0]                  reg2dp_src_base_addr_high,
  input  logic [31:0]                  reg2dp_src_base_addr_low,
  input  cdp_rdma_ig_pkg::stride_t     reg2dp_src_line_stride,
  input  cdp_rdma_ig_pkg::stride_t     reg2dp_src_surface_stride,
  input  logic                         eg2ig_done,
  input  logic                         dma_rd_req_ready,
  input  logic                         cq_wr_prdy,
  output logic                         dma_rd_req_valid,
  output logic [`CDP_DMA_PD_BW-1:0]    dma_rd_req_pd,
  output logic                         cq_wr_pvld,
  output cdp_rdma_ig_pkg::cq_pd_t      cq_wr_pd,
  output cdp_rdma_ig_pkg::perf_t       dp2reg_d0_perf_read_stall,
  output cdp_rdma_ig_pkg::perf_t       dp2reg_d1_perf_read_stall
);
  import cdp_rdma_ig_pkg::*;

  logic                    op_load;
  logic                    op_done;
  logic                    cmd_accept;
  logic                    is_last_w;
  logic                    is_last_h;
  logic                    is_last_c;
  req_size_t               req_size;
  addr_t                   req_addr;
  logic [`CDP_SIZE_BW-1:0] dma_req_size;

  // sequencing, walk counters and handshake
  cdp_rdma_ig_req_seq u_req_seq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (reg2dp_op_en),
    .eg2ig_done      (eg2ig_done),
    .width           (reg2dp_width),
    .height          (reg2dp_height),
    .channel         (reg2dp_channel),
    .dma_ready       (dma_rd_req_ready),
    .cq_ready        (cq_wr_prdy),
    .dma_valid       (dma_rd_req_valid),
    .cq_valid        (cq_wr_pvld),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .op_done         (op_done),
    .is_last_w       (is_last_w),
    .is_last_h       (is_last_h),
    .is_last_c       (is_last_c),
    .req_size        (req_size)
  );

  cdp_rdma_ig_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .is_last_w       (is_last_w),
    .is_last_c       (is_last_c),
    .req_size        (req_size),
    .base_addr_high  (reg2dp_src_base_addr_high),
    .base_addr_low   (reg2dp_src_base_addr_low),
    .line_stride     (reg2dp_src_line_stride),
    .surf_stride     (reg2dp_src_surface_stride),
    .req_addr        (req_addr)
  );

  cdp_rdma_ig_stall_perf u_stall_perf (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .dma_en             (reg2dp_dma_en),
    .dma_valid          (dma_rd_req_valid),
    .dma_ready          (dma_rd_req_ready),
    .op_done            (op_done),
    .perf_read_stall_d0 (dp2reg_d0_perf_read_stall),
    .perf_read_stall_d1 (dp2reg_d1_perf_read_stall)
  );

  // ==========================================================
  // payload packing
  // ==========================================================
  // size sits above the address, upper size bits always zero
  assign dma_req_size  = `CDP_SIZE_BW'(req_size);
  assign dma_rd_req_pd = {dma_req_size, req_addr[`CDP_MEM_ADDR_BW-1:0]};

  // alignment is not tracked, align stays zero
  assign cq_wr_pd = '{last_c: is_last_c,
                      last_h: is_last_h,
                      last_w: is_last_w,
                      align:  1'b0,
                      size:   req_size};

endmodule

//--- testbench/tb_cdp_rdma_ig_tests.svh
// directed tests for the cdp read dma ingress included inside the testbench top
// each test programs a cube, runs whole layers and checks per cycle at negedge

`ifndef TB_CDP_RDMA_IG_TESTS_SVH
`define TB_CDP_RDMA_IG_TESTS_SVH

  // program cube registers and queue the reference walk
  task automatic set_cube(input int w, input int h, input int c);
    @(posedge nvdla_core_clk);
    width <= dim_t'(w);
    height <= dim_t'(h);
    channel <= dim_t'(c);
    build_model(w, h, c, {base_high, base_low}, 64'(line_stride), 64'(surf_stride));
  endtask

  task automatic drive_ready(input int mode, input int cycle);
    case (mode)
      READY_HIGH: begin
        dma_ready <= 1'b1;
        cq_ready <= 1'b1;
      end
      READY_RANDOM: begin
        dma_ready <= rand_bit();
        cq_ready <= rand_bit();
      end
      default: begin
        // rotate dma only, cq only, then both
        dma_ready <= (cycle % 3) != 1;
        cq_ready <= (cycle % 3) != 0;
      end
    endcase
  endtask

  // ============================================================
  // per-cycle monitor called at negedge
  // ============================================================
  task automatic sample_cycle();
    if (dma_rd_req_valid && !dma_ready) begin
      wait_seen++;
      if (dma_en) begin
        stall_seen++;
      end
    end
    // one-sided ready must never complete a transfer
    if (dma_ready != cq_ready) begin
      check_value(64'(dma_rd_req_valid & dma_ready), 64'd0, "one-sided dma accept");
      check_value(64'(cq_wr_pvld & cq_ready), 64'd0, "one-sided cq accept");
    end
    if (dma_rd_req_valid && dma_ready) begin
      if (exp_addr_q.size() == 0) begin
        error_count++;
        $display("read request at %0t ns with no request left in the reference walk", $time);
      end else begin
        accept_seen++;
        check_value(64'(cq_wr_pvld & cq_ready), 64'd1, "cq accept paired with dma accept");
        check_value(dma_rd_req_pd[`CDP_MEM_ADDR_BW-1:0], exp_addr_q[0], "request address");
        check_value(64'(dma_rd_req_pd[`CDP_DMA_PD_BW-1:`CDP_MEM_ADDR_BW]),
                    64'(exp_size_q[0]), "request size");
        check_value(64'(cq_wr_pd.size), 64'(exp_size_q[0]), "context size");
        check_value(64'(cq_wr_pd.align), 64'd0, "context align");
        check_value(64'({cq_wr_pd.last_c, cq_wr_pd.last_h, cq_wr_pd.last_w}),
                    64'(exp_last_q[0]), "context last flags c/h/w");
        void'(exp_addr_q.pop_front());
        void'(exp_size_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
  endtask

  // start a layer, run it to the cube end, then check the perf registers
  task automatic run_layer(input int mode);
    int cycles;
    cycles = 0;
    stall_seen = 0;
    wait_seen = 0;
    accept_seen = 0;
    @(posedge nvdla_core_clk);
    op_en <= 1'b1;
    drive_ready(mode, cycles);
    while (exp_addr_q.size() != 0 && cycles < LAYER_LIMIT) begin
      @(negedge nvdla_core_clk);
      sample_cycle();
      @(posedge nvdla_core_clk);
      op_en <= 1'b0;
      cycles++;
      drive_ready(mode, cycles);
    end
    if (exp_addr_q.size() != 0) begin
      timeout_count++;
      $display("timeout, layer still had %0d requests left after %0d cycles",
               exp_addr_q.size(), cycles);
      exp_addr_q.delete();
      exp_size_q.delete();
      exp_last_q.delete();
    end
    // registers take the count one clock after the cube-end accept
    @(negedge nvdla_core_clk);
    if (layer_parity) begin
      exp_d1 = perf_t'(stall_seen);
    end else begin
      exp_d0 = perf_t'(stall_seen);
    end
    layer_parity = ~layer_parity;
    check_value(64'(d0_stall), 64'(exp_d0), "d0 read stall count");
    check_value(64'(d1_stall), 64'(exp_d1), "d1 read stall count");
  endtask

  // optional idle check with op_en high, then the egress done pulse
  task automatic end_layer(input int idle);
    for (int i = 0; i < idle; i++) begin
      @(posedge nvdla_core_clk);
      op_en <= 1'b1;
      dma_ready <= 1'b1;
      cq_ready <= 1'b1;
      @(negedge nvdla_core_clk);
      check_value(64'(dma_rd_req_valid | cq_wr_pvld), 64'd0, "valid before egress done");
    end
    @(posedge nvdla_core_clk);
    op_en <= 1'b0;
    eg2ig_done <= 1'b1;
    @(posedge nvdla_core_clk);
    eg2ig_done <= 1'b0;
  endtask

  // ============================================================
  // tests
  // ============================================================
  task automatic check_reset_state();
    @(negedge nvdla_core_clk);
    check_value(64'(dma_rd_req_valid), 64'd0, "dma valid after reset");
    check_value(64'(cq_wr_pvld), 64'd0, "cq valid after reset");
    check_value(64'(d0_stall), 64'd0, "d0 stall after reset");
    check_value(64'(d1_stall), 64'd0, "d1 stall after reset");
  endtask

  task automatic walk_ready_high();
    // one group of six, one block, one line
    set_cube(5, 0, 7);
    run_layer(READY_HIGH);
    end_layer(0);
    // 7, 7, 3 sized groups, two blocks, two lines
    set_cube(19, 1, 15);
    run_layer(READY_HIGH);
    end_layer(0);
    // one-element tail group, four blocks, three lines
    set_cube(8, 2, 31);
    run_layer(READY_HIGH);
    end_layer(0);
  endtask

  task automatic check_context_entries();
    set_cube(19, 1, 15);
    run_layer(READY_ONE_SIDED);
    // 3 groups x 2 blocks x 2 lines
    check_value(64'(accept_seen), 64'd12, "accepted context entries");
    end_layer(0);
  endtask

  task automatic walk_back_pressure();
    set_cube(19, 1, 15);
    run_layer(READY_RANDOM);
    check_value(64'(wait_seen != 0), 64'd1, "stall cycles seen under back-pressure");
    end_layer(0);
  endtask

  // lands in d1 while d0 keeps the previous layer's count
  task automatic check_second_layer();
    set_cube(8, 1, 15);
    run_layer(READY_RANDOM);
    end_layer(6);
  endtask

  task automatic check_stall_disabled();
    @(posedge nvdla_core_clk);
    dma_en <= 1'b0;
    set_cube(19, 1, 15);
    run_layer(READY_RANDOM);
    check_value(64'(wait_seen != 0), 64'd1, "back-pressure with stall counting off");
    check_value(64'(d0_stall), 64'd0, "d0 with stall counting off");
    end_layer(0);
  endtask

`endif

//--- testbench/tb_cdp_rdma_ig.sv
// testbench for the cdp read dma ingress
// walks whole layers and checks every accepted request and context entry
// against a reference walk of the cube; tests live in the included header

`include "cdp_rdma_ig_params.svh"

module tb_cdp_rdma_ig;
  timeunit 1ns;
  timeprecision 1ps;

  import cdp_rdma_ig_pkg::*;

  localparam int LAYER_LIMIT     = 4000;
  localparam int READY_HIGH      = 0;
  localparam int READY_RANDOM    = 1;
  localparam int READY_ONE_SIDED = 2;

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic                      op_en;
  logic                      dma_en;
  dim_t                      width;
  dim_t                      height;
  dim_t                      channel;
  logic [31:0]               base_high;
  logic [31:0]               base_low;
  stride_t                   line_stride;
  stride_t                   surf_stride;
  logic                      eg2ig_done;
  logic                      dma_ready;
  logic                      cq_ready;
  logic                      dma_rd_req_valid;
  logic [`CDP_DMA_PD_BW-1:0] dma_rd_req_pd;
  logic                      cq_wr_pvld;
  cq_pd_t                    cq_wr_pd;
  perf_t                     d0_stall;
  perf_t                     d1_stall;

  // expected request stream with one entry per accept
  logic [63:0] exp_addr_q[$];
  req_size_t   exp_size_q[$];
  logic [2:0]  exp_last_q[$];

  logic [31:0] lfsr;
  int          check_count;
  int          error_count;
  int          timeout_count;
  int          stall_seen;
  int          wait_seen;
  int          accept_seen;
  logic        layer_parity;
  perf_t       exp_d0;
  perf_t       exp_d1;

  cdp_rdma_ig uut (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .reg2dp_op_en              (op_en),
    .reg2dp_dma_en             (dma_en),
    .reg2dp_width              (width),
    .reg2dp_height             (height),
    .reg2dp_channel            (channel),
    .reg2dp_src_base_addr_high (base_high),
    .reg2dp_src_base_addr_low  (base_low),
    .reg2dp_src_line_stride    (line_stride),
    .reg2dp_src_surface_stride (surf_stride),
    .eg2ig_done                (eg2ig_done),
    .dma_rd_req_ready          (dma_ready),
    .cq_wr_prdy                (cq_ready),
    .dma_rd_req_valid          (dma_rd_req_valid),
    .dma_rd_req_pd             (dma_rd_req_pd),
    .cq_wr_pvld                (cq_wr_pvld),
    .cq_wr_pd                  (cq_wr_pd),
    .dp2reg_d0_perf_read_stall (d0_stall),
    .dp2reg_d1_perf_read_stall (d1_stall)
  );

  // ============================================================
  // helpers
  // ============================================================
  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // one step per bit taken
  function automatic logic rand_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  // reference walk over lines, then width groups of eight, then channel blocks
  task automatic build_model(input int w, input int h, input int c, input logic [63:0] base,
                             input logic [63:0] line, input logic [63:0] surf);
    int          ngrp;
    int          nblk;
    int          sz;
    logic [63:0] line_base;
    logic [63:0] grp_base;
    logic [63:0] addr;
    ngrp = (w + 1 + 7) / 8;
    nblk = (c >> `CDP_ATOMIC_SHIFT) + 1;
    line_base = base;
    for (int y = 0; y <= h; y++) begin
      grp_base = line_base;
      for (int g = 0; g < ngrp; g++) begin
        // full groups up front and the remainder in the last or only one
        sz = (g == ngrp - 1) ? (w % 8) : 7;
        addr = grp_base;
        for (int k = 0; k < nblk; k++) begin
          exp_addr_q.push_back(addr);
          exp_size_q.push_back(req_size_t'(sz));
          exp_last_q.push_back({k == nblk - 1, y == h, g == ngrp - 1});
          addr = addr + surf;
        end
        grp_base = grp_base + 64'((sz + 1) << `CDP_ATOMIC_SHIFT);
      end
      line_base = line_base + line;
    end
  endtask

  `include "tb_cdp_rdma_ig_tests.svh"

  // 20 ns clock
  initial begin
    nvdla_core_clk = 1'b0;
    forever #10 nvdla_core_clk = ~nvdla_core_clk;
  end

  initial begin
    nvdla_core_rstn = 1'b0;
    op_en = 1'b0;
    dma_en = 1'b1;
    width = '0;
    height = '0;
    channel = '0;
    base_high = 32'h0000_0001;
    base_low = 32'h8000_0100;
    line_stride = 32'h0000_1000;
    surf_stride = 32'h0000_0100;
    eg2ig_done = 1'b0;
    dma_ready = 1'b0;
    cq_ready = 1'b0;
    lfsr = 32'h846d7e34;
    check_count = 0;
    error_count = 0;
    timeout_count = 0;
    layer_parity = 1'b0;
    exp_d0 = '0;
    exp_d1 = '0;
    repeat (2) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;

    check_reset_state();
    walk_ready_high();
    check_context_entries();
    walk_back_pressure();
    check_second_layer();
    check_stall_disabled();

    repeat (2) @(posedge nvdla_core_clk);
    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- cdp_rdma_ig.f
+incdir+source
+incdir+testbench
source/cdp_rdma_ig_pkg.sv
source/cdp_rdma_ig_req_seq.sv
source/cdp_rdma_ig_addr_gen.sv
source/cdp_rdma_ig_stall_perf.sv
source/cdp_rdma_ig.sv
testbench/tb_cdp_rdma_ig.sv

//--- Makefile
TOP := tb_cdp_rdma_ig

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cdp_rdma_ig.f source/*.sv source/*.svh testbench/*.sv testbench/*.svh
	verilator --binary --timing --timescale 1ns/1ps -f cdp_rdma_ig.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps -f cdp_rdma_ig.f \
		--top-module cdp_rdma_ig

clean:
	rm -rf obj_dir
